// File: compile.f
source/display_pkg.sv
source/sprite_pkg.sv
source/status_controller.sv
source/bcd_digits.sv
source/sprite_fetch.sv
source/shape_layers.sv
source/status_display.sv
verification/sprite_rom_model.sv
verification/tb_status_display.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -j 0 --top-module tb_status_display \
    -f compile.f -o sim_status_display > build.log 2>&1 \
    && ./obj_dir/sim_status_display > sim.log 2>&1 \
    || echo "build or simulation stopped with an error, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/bcd_digits.sv
`timescale 1ns/1ns

module bcd_digits (
    input  logic       clk_100mhz,
    input  logic       rst,
    input  logic [7:0] number,
    output logic       number_over_99,
    output logic [3:0] tens,
    output logic [3:0] ones
);

    // number modulo 100
    logic [6:0] below_100;

    always_comb begin
        if (number >= 8'd200) begin
            below_100 = 7'(number - 8'd200);
        end else if (number >= 8'd100) begin
            below_100 = 7'(number - 8'd100);
        end else begin
            below_100 = number[6:0];
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            number_over_99 <= 1'b0;
            tens           <= '0;
            ones           <= '0;
        end else begin
            number_over_99 <= (number > 8'd99);
            tens           <= 4'(below_100 / 7'd10);
            ones           <= 4'(below_100 % 7'd10);
        end
    end

endmodule

// File: source/display_pkg.sv
package display_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // screen geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int SCREEN_W = 1024;
    localparam int SCREEN_H = 768;

    typedef logic [10:0] hcount_t;
    typedef logic [9:0]  vcount_t;

    // 4 bits each of red, green, blue
    typedef logic [11:0] color_t;

    typedef enum logic [1:0] {
        ST_PAUSED  = 2'd0,
        ST_RUNNING = 2'd1,
        ST_ERROR   = 2'd2,
        ST_BOOT    = 2'd3
    } status_t;

    // solid rectangles, none overlap in any status
    localparam int TOP_BAR_X    = 700;
    localparam int TOP_BAR_Y    = 0;
    localparam int TOP_BAR_W    = 250;
    localparam int TOP_BAR_H    = 100;
    localparam int BOTTOM_BAR_X = 0;
    localparam int BOTTOM_BAR_Y = SCREEN_H - 100;
    localparam int BOTTOM_BAR_W = SCREEN_W;
    localparam int BOTTOM_BAR_H = 100;
    localparam int ERROR_BOX_X  = 162;
    localparam int ERROR_BOX_Y  = 234;
    localparam int ERROR_BOX_W  = 700;
    localparam int ERROR_BOX_H  = 300;
    localparam int PROGRESS_Y   = 374;
    localparam int PROGRESS_H   = 20;
    localparam int PROGRESS_MAX = SCREEN_W;

    localparam color_t GREY     = 12'h666;
    localparam color_t RED      = 12'hF22;
    localparam color_t BLUE     = 12'h17A;
    localparam color_t WHITE    = 12'hFFF;
    localparam color_t LOGO_RED = 12'hF00;

    // position in, pixel out
    localparam int PIPE_DEPTH = 3;

    // half-open rectangle test
    function automatic logic in_rect(int h, int v, int x, int y, int w, int ht);
        return (h >= x) && (h < x + w) && (v >= y) && (v < y + ht);
    endfunction

endpackage

// File: source/shape_layers.sv
`timescale 1ns/1ns

module shape_layers (
    input  logic                 clk_100mhz,
    input  logic                 rst,
    input  display_pkg::hcount_t hcount,
    input  display_pkg::vcount_t vcount,
    input  logic                 top_bar_en,
    input  logic                 bottom_bar_en,
    input  logic                 error_box_en,
    input  logic                 progress_en,
    input  display_pkg::color_t  top_bar_color,
    input  display_pkg::color_t  bottom_bar_color,
    input  display_pkg::color_t  error_box_color,
    input  logic [10:0]          progress_width,
    output display_pkg::color_t  shape_pixel
);
    import display_pkg::*;

    color_t pix_d;
    // aligns with the sprite color at n+2
    color_t pix_q [PIPE_DEPTH-1];

    always_comb begin
        pix_d = '0;
        if (top_bar_en && in_rect(int'(hcount), int'(vcount),
                                  TOP_BAR_X, TOP_BAR_Y, TOP_BAR_W, TOP_BAR_H)) begin
            pix_d = top_bar_color;
        end else if (bottom_bar_en && in_rect(int'(hcount), int'(vcount), BOTTOM_BAR_X,
                                              BOTTOM_BAR_Y, BOTTOM_BAR_W, BOTTOM_BAR_H)) begin
            pix_d = bottom_bar_color;
        end else if (error_box_en && in_rect(int'(hcount), int'(vcount), ERROR_BOX_X,
                                             ERROR_BOX_Y, ERROR_BOX_W, ERROR_BOX_H)) begin
            pix_d = error_box_color;
        end else if (progress_en && in_rect(int'(hcount), int'(vcount), 0, PROGRESS_Y,
                                            int'(progress_width), PROGRESS_H)) begin
            pix_d = WHITE;
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            for (int i = 0; i < PIPE_DEPTH - 1; i++) begin
                pix_q[i] <= '0;
            end
        end else begin
            pix_q[0] <= pix_d;
            for (int i = 1; i < PIPE_DEPTH - 1; i++) begin
                pix_q[i] <= pix_q[i-1];
            end
        end
    end

    assign shape_pixel = pix_q[PIPE_DEPTH-2];

endmodule

// File: source/sprite_fetch.sv
`timescale 1ns/1ns

module sprite_fetch (
    input  logic                                clk_100mhz,
    input  logic                                rst,
    input  display_pkg::hcount_t                hcount,
    input  display_pkg::vcount_t                vcount,
    input  logic [sprite_pkg::NUM_SPRITES-1:0]  sprite_en,
    input  logic [3:0]                          tens,
    input  logic [3:0]                          ones,
    output sprite_pkg::atlas_adr_t              sprite_adr,
    output display_pkg::color_t                 sprite_color
);
    import display_pkg::*;
    import sprite_pkg::*;

    logic       hit;
    atlas_adr_t adr_d;
    color_t     color_d;
    color_t     color_q;

    ////////////////////////////////////////////////////////////////////////////
    // priority hit test
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        int left;
        int top;
        int w;
        int h;

        hit     = 1'b0;
        adr_d   = '0;
        color_d = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            left = SPR_LEFT[i];
            top  = SPR_TOP[i];
            w    = SPR_RIGHT[i] - SPR_LEFT[i];
            h    = SPR_BOTTOM[i] - SPR_TOP[i];
            // digit slots look up their glyph
            if (i == int'(SPR_TENS) || i == int'(SPR_ONES)) begin
                left = (i == int'(SPR_TENS)) ? GLYPH_LEFT[tens] : GLYPH_LEFT[ones];
                top  = GLYPH_TOP;
                w    = GLYPH_W;
                h    = GLYPH_BOTTOM - GLYPH_TOP;
            end
            if (!hit && sprite_en[i] &&
                in_rect(int'(hcount), int'(vcount), SPR_X[i], SPR_Y[i], w, h)) begin
                hit     = 1'b1;
                adr_d   = atlas_adr_t'(ATLAS_W * (int'(vcount) - SPR_Y[i] + top)
                                       + int'(hcount) - SPR_X[i] + left);
                color_d = SPR_COLOR[i];
            end
        end
    end

    // address at n+1 and color at n+2 to meet the atlas bit
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            sprite_adr   <= '0;
            color_q      <= '0;
            sprite_color <= '0;
        end else begin
            sprite_adr   <= adr_d;
            color_q      <= color_d;
            sprite_color <= color_q;
        end
    end

    a_adr_in_atlas: assert property (
        @(posedge clk_100mhz) disable iff (rst)
        sprite_adr < atlas_adr_t'(ATLAS_W * ATLAS_H)
    );

endmodule

// File: source/sprite_pkg.sv
package sprite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // one-bit sprite atlas
    ////////////////////////////////////////////////////////////////////////////

    localparam int ATLAS_W = 610;
    localparam int ATLAS_H = 356;

    typedef logic [17:0] atlas_adr_t;

    localparam int NUM_SPRITES = 10;

    // listed in priority order, first hit wins
    typedef enum logic [3:0] {
        SPR_LOGO        = 4'd0,
        SPR_COLLECTING  = 4'd1,
        SPR_HUNDREDS    = 4'd2,
        SPR_BPM         = 4'd3,
        SPR_TENS        = 4'd4,
        SPR_ONES        = 4'd5,
        SPR_TITLE       = 4'd6,
        SPR_ERROR_MSG   = 4'd7,
        SPR_PAUSED_MSG  = 4'd8,
        SPR_BOOTING_MSG = 4'd9
    } sprite_id_t;

    // screen placement
    localparam int SPR_X [NUM_SPRITES] = '{10, 624, 760, 785, 790, 840, 168, 540, 624, 400};
    localparam int SPR_Y [NUM_SPRITES] = '{20, 678, 20, 110, 20, 20, 70, 350, 683, 200};

    // atlas rectangles; tens and ones come from the glyph table instead
    localparam int SPR_LEFT   [NUM_SPRITES] = '{0, 251, 144, 178, 0, 0, 261, 437, 251, 251};
    localparam int SPR_RIGHT  [NUM_SPRITES] = '{143, 610, 172, 245, 0, 0, 580, 576, 437, 463};
    localparam int SPR_TOP    [NUM_SPRITES] = '{223, 61, 281, 229, 0, 0, 0, 134, 134, 205};
    localparam int SPR_BOTTOM [NUM_SPRITES] = '{355, 134, 355, 265, 0, 0, 61, 195, 205, 281};

    localparam display_pkg::color_t SPR_COLOR [NUM_SPRITES] = '{
        display_pkg::LOGO_RED,
        display_pkg::WHITE,
        display_pkg::WHITE,
        display_pkg::LOGO_RED,
        display_pkg::WHITE,
        display_pkg::WHITE,
        display_pkg::LOGO_RED,
        display_pkg::WHITE,
        display_pkg::WHITE,
        display_pkg::WHITE
    };

    ////////////////////////////////////////////////////////////////////////////
    // digit glyphs 0-9, one row of the atlas
    ////////////////////////////////////////////////////////////////////////////

    localparam int GLYPH_LEFT [10] = '{47, 99, 151, 203, 255, 307, 359, 411, 463, 515};
    localparam int GLYPH_W      = 48;
    localparam int GLYPH_TOP    = 281;
    localparam int GLYPH_BOTTOM = 355;

endpackage

// File: source/status_controller.sv
`timescale 1ns/1ns

module status_controller #(
    parameter int PROGRESS_STEP_LOG2 = 19
) (
    input  logic                                 clk_100mhz,
    input  logic                                 rst,
    input  display_pkg::status_t                 status,
    input  logic                                 number_over_99,
    output logic [sprite_pkg::NUM_SPRITES-1:0]   sprite_en,
    output logic                                 top_bar_en,
    output logic                                 bottom_bar_en,
    output logic                                 error_box_en,
    output logic                                 progress_en,
    output display_pkg::color_t                  top_bar_color,
    output display_pkg::color_t                  bottom_bar_color,
    output display_pkg::color_t                  error_box_color,
    output logic [10:0]                          progress_width
);
    import display_pkg::*;
    import sprite_pkg::*;

    logic [PROGRESS_STEP_LOG2-1:0] progress_div;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            sprite_en        <= '0;
            top_bar_en       <= 1'b0;
            bottom_bar_en    <= 1'b0;
            error_box_en     <= 1'b0;
            progress_en      <= 1'b0;
            top_bar_color    <= '0;
            bottom_bar_color <= '0;
            error_box_color  <= '0;
        end else begin
            // logo and title show in every status
            sprite_en              <= '0;
            sprite_en[SPR_LOGO]    <= 1'b1;
            sprite_en[SPR_TITLE]   <= 1'b1;
            top_bar_en       <= 1'b0;
            bottom_bar_en    <= 1'b0;
            error_box_en     <= 1'b0;
            progress_en      <= 1'b0;
            top_bar_color    <= GREY;
            bottom_bar_color <= GREY;
            error_box_color  <= WHITE;

            case (status)
                ST_PAUSED: begin
                    sprite_en[SPR_PAUSED_MSG] <= 1'b1;
                    sprite_en[SPR_TENS]       <= 1'b1;
                    sprite_en[SPR_ONES]       <= 1'b1;
                    sprite_en[SPR_BPM]        <= 1'b1;
                    top_bar_en    <= 1'b1;
                    bottom_bar_en <= 1'b1;
                end
                ST_RUNNING: begin
                    sprite_en[SPR_COLLECTING] <= 1'b1;
                    sprite_en[SPR_TENS]       <= 1'b1;
                    sprite_en[SPR_ONES]       <= 1'b1;
                    sprite_en[SPR_BPM]        <= 1'b1;
                    sprite_en[SPR_HUNDREDS]   <= number_over_99;
                    top_bar_en       <= 1'b1;
                    bottom_bar_en    <= 1'b1;
                    top_bar_color    <= RED;
                    bottom_bar_color <= BLUE;
                end
                ST_ERROR: begin
                    sprite_en[SPR_ERROR_MSG] <= 1'b1;
                    top_bar_en      <= 1'b1;
                    bottom_bar_en   <= 1'b1;
                    error_box_en    <= 1'b1;
                    error_box_color <= RED;
                end
                ST_BOOT: begin
                    sprite_en[SPR_BOOTING_MSG] <= 1'b1;
                    progress_en <= 1'b1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // boot progress bar, one pixel per divider wrap
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_100mhz) begin
        if (rst || status != ST_BOOT) begin
            progress_div   <= '0;
            progress_width <= '0;
        end else begin
            progress_div <= progress_div + 1'b1;
            if (&progress_div && progress_width < 11'(PROGRESS_MAX)) begin
                progress_width <= progress_width + 1'b1;
            end
        end
    end

    a_progress_bounded: assert property (
        @(posedge clk_100mhz) disable iff (rst)
        progress_width <= 11'(PROGRESS_MAX)
    );

endmodule

// File: source/status_display.sv
`timescale 1ns/1ns

module status_display #(
    parameter int PROGRESS_STEP_LOG2 = 19
) (
    input  logic                   clk_100mhz,
    input  logic                   rst,
    input  display_pkg::hcount_t   hcount,
    input  display_pkg::vcount_t   vcount,
    input  display_pkg::status_t   status,
    input  logic [7:0]             number,
    input  logic                   sprite_bit,
    output sprite_pkg::atlas_adr_t sprite_adr,
    output logic [3:0]             r_out,
    output logic [3:0]             g_out,
    output logic [3:0]             b_out
);
    import display_pkg::*;
    import sprite_pkg::*;

    logic [NUM_SPRITES-1:0] sprite_en;
    logic                   top_bar_en;
    logic                   bottom_bar_en;
    logic                   error_box_en;
    logic                   progress_en;
    color_t                 top_bar_color;
    color_t                 bottom_bar_color;
    color_t                 error_box_color;
    logic [10:0]            progress_width;
    logic                   number_over_99;
    logic [3:0]             tens;
    logic [3:0]             ones;
    color_t                 sprite_color;
    color_t                 shape_pixel;

    status_controller #(
        .PROGRESS_STEP_LOG2 (PROGRESS_STEP_LOG2)
    ) i_status_controller (
        .clk_100mhz       (clk_100mhz),
        .rst              (rst),
        .status           (status),
        .number_over_99   (number_over_99),
        .sprite_en        (sprite_en),
        .top_bar_en       (top_bar_en),
        .bottom_bar_en    (bottom_bar_en),
        .error_box_en     (error_box_en),
        .progress_en      (progress_en),
        .top_bar_color    (top_bar_color),
        .bottom_bar_color (bottom_bar_color),
        .error_box_color  (error_box_color),
        .progress_width   (progress_width)
    );

    bcd_digits i_bcd_digits (
        .clk_100mhz     (clk_100mhz),
        .rst            (rst),
        .number         (number),
        .number_over_99 (number_over_99),
        .tens           (tens),
        .ones           (ones)
    );

    sprite_fetch i_sprite_fetch (
        .clk_100mhz   (clk_100mhz),
        .rst          (rst),
        .hcount       (hcount),
        .vcount       (vcount),
        .sprite_en    (sprite_en),
        .tens         (tens),
        .ones         (ones),
        .sprite_adr   (sprite_adr),
        .sprite_color (sprite_color)
    );

    shape_layers i_shape_layers (
        .clk_100mhz       (clk_100mhz),
        .rst              (rst),
        .hcount           (hcount),
        .vcount           (vcount),
        .top_bar_en       (top_bar_en),
        .bottom_bar_en    (bottom_bar_en),
        .error_box_en     (error_box_en),
        .progress_en      (progress_en),
        .top_bar_color    (top_bar_color),
        .bottom_bar_color (bottom_bar_color),
        .error_box_color  (error_box_color),
        .progress_width   (progress_width),
        .shape_pixel      (shape_pixel)
    );

    // sprite over shapes; a miss carries color 0
    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            {r_out, g_out, b_out} <= '0;
        end else if (sprite_bit && sprite_color != '0) begin
            {r_out, g_out, b_out} <= sprite_color;
        end else begin
            {r_out, g_out, b_out} <= shape_pixel;
        end
    end

endmodule

// File: verification/sprite_rom_model.sv
`timescale 1ns/1ns

module sprite_rom_model (
    input  logic                   clk_100mhz,
    input  sprite_pkg::atlas_adr_t adr,
    output logic                   data
);
    import sprite_pkg::*;

    localparam int DEPTH = ATLAS_W * ATLAS_H;

    logic mem [DEPTH];

    // bit 2 lights a pixel, plus a sparse scatter over the whole address
    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[atlas_adr_t'(a)] = (a[2] == 1'b1) || (a % 13 == 0);
        end
    end

    // one-cycle read, like a block RAM
    always_ff @(posedge clk_100mhz) begin
        data <= mem[adr];
    end

endmodule

// File: verification/tb_status_display.sv
`timescale 1ns/1ns

module tb_status_display;
    import display_pkg::*;
    import sprite_pkg::*;

    localparam int STEP_LOG2 = 4;
    // upper bounds of the test program below
    localparam int N_POSITIONS    = 300;
    localparam int N_STEPS        = 70;
    localparam int TIMEOUT_CYCLES = 2 * (N_POSITIONS * 4 + N_STEPS * 16);
    localparam int BAR_STEPS [3]  = '{8, 30, N_STEPS};

    logic       clk_100mhz = 1'b0;
    logic       rst;
    hcount_t    hcount;
    vcount_t    vcount;
    status_t    status;
    logic [7:0] number;
    logic       sprite_bit;
    atlas_adr_t sprite_adr;
    logic [3:0] r_out;
    logic [3:0] g_out;
    logic [3:0] b_out;

    int         cycle = 0;
    int         mode_cycle = 0;
    int         cur_pw = 0;
    int         adr_errors = 0;
    int         color_errors = 0;
    // expected results indexed by the cycle they are due in
    atlas_adr_t adr_exp [8];
    int         adr_due [8] = '{default: -1};
    color_t     rgb_exp [8];
    int         rgb_due [8] = '{default: -1};

    status_display #(
        .PROGRESS_STEP_LOG2 (STEP_LOG2)
    ) i_status_display (
        .clk_100mhz (clk_100mhz),
        .rst        (rst),
        .hcount     (hcount),
        .vcount     (vcount),
        .status     (status),
        .number     (number),
        .sprite_bit (sprite_bit),
        .sprite_adr (sprite_adr),
        .r_out      (r_out),
        .g_out      (g_out),
        .b_out      (b_out)
    );

    sprite_rom_model i_sprite_rom_model (
        .clk_100mhz (clk_100mhz),
        .adr        (sprite_adr),
        .data       (sprite_bit)
    );

    always #5 clk_100mhz = ~clk_100mhz;

    always @(posedge clk_100mhz) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic inside_box(input int h, input int v, input int x, input int y,
                                        input int w, input int ht);
        return h >= x && h < x + w && v >= y && v < y + ht;
    endfunction

    // same rule the atlas model is filled with
    function automatic logic atlas_bit(input atlas_adr_t a);
        return a[2] || (int'(a) % 13 == 0);
    endfunction

    function automatic color_t ref_pixel(input status_t st, input logic [7:0] num,
                                         input int pw, input int h, input int v,
                                         output atlas_adr_t adr);
        logic [NUM_SPRITES-1:0] en;
        logic                   hit;
        logic [3:0]             digit;
        color_t                 spr;
        color_t                 shape;
        int                     left;
        int                     top;
        int                     w;
        int                     ht;

        en = '0;
        en[SPR_LOGO]  = 1'b1;
        en[SPR_TITLE] = 1'b1;
        if (st == ST_PAUSED || st == ST_RUNNING) begin
            en[SPR_TENS] = 1'b1;
            en[SPR_ONES] = 1'b1;
            en[SPR_BPM]  = 1'b1;
        end
        en[SPR_PAUSED_MSG]  = (st == ST_PAUSED);
        en[SPR_COLLECTING]  = (st == ST_RUNNING);
        en[SPR_HUNDREDS]    = (st == ST_RUNNING) && (num > 8'd99);
        en[SPR_ERROR_MSG]   = (st == ST_ERROR);
        en[SPR_BOOTING_MSG] = (st == ST_BOOT);

        shape = '0;
        if (st == ST_BOOT) begin
            if (h < pw && inside_box(h, v, 0, PROGRESS_Y, SCREEN_W, PROGRESS_H)) begin
                shape = WHITE;
            end
        end else if (inside_box(h, v, TOP_BAR_X, TOP_BAR_Y, TOP_BAR_W, TOP_BAR_H)) begin
            shape = (st == ST_RUNNING) ? RED : GREY;
        end else if (inside_box(h, v, BOTTOM_BAR_X, BOTTOM_BAR_Y,
                                BOTTOM_BAR_W, BOTTOM_BAR_H)) begin
            shape = (st == ST_RUNNING) ? BLUE : GREY;
        end else if (st == ST_ERROR && inside_box(h, v, ERROR_BOX_X, ERROR_BOX_Y,
                                                  ERROR_BOX_W, ERROR_BOX_H)) begin
            shape = RED;
        end

        // first enabled sprite in priority order wins
        hit = 1'b0;
        spr = '0;
        adr = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            left = SPR_LEFT[i];
            top  = SPR_TOP[i];
            w    = SPR_RIGHT[i] - SPR_LEFT[i];
            ht   = SPR_BOTTOM[i] - SPR_TOP[i];
            if (i == int'(SPR_TENS) || i == int'(SPR_ONES)) begin
                digit = (i == int'(SPR_TENS)) ? 4'((int'(num) % 100) / 10)
                                              : 4'(int'(num) % 10);
                left = GLYPH_LEFT[digit];
                top  = GLYPH_TOP;
                w    = GLYPH_W;
                ht   = GLYPH_BOTTOM - GLYPH_TOP;
            end
            if (!hit && en[i] && inside_box(h, v, SPR_X[i], SPR_Y[i], w, ht)) begin
                hit = 1'b1;
                spr = SPR_COLOR[i];
                adr = atlas_adr_t'((v - SPR_Y[i] + top) * ATLAS_W + (h - SPR_X[i] + left));
            end
        end

        if (hit && atlas_bit(adr)) begin
            return spr;
        end else begin
            return shape;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    // address due one cycle on and pixel three cycles on
    task automatic schedule_checks(input atlas_adr_t adr, input color_t rgb);
        logic [2:0] slot;

        slot = 3'(cycle + 1);
        adr_exp[slot] = adr;
        adr_due[slot] = cycle + 1;
        slot = 3'(cycle + PIPE_DEPTH);
        rgb_exp[slot] = rgb;
        rgb_due[slot] = cycle + PIPE_DEPTH;
    endtask

    task automatic drive_pos(input int h, input int v);
        atlas_adr_t adr;
        color_t     rgb;

        @(negedge clk_100mhz);
        hcount = hcount_t'(h);
        vcount = vcount_t'(v);
        rgb = ref_pixel(status, number, cur_pw, h, v, adr);
        schedule_checks(adr, rgb);
    endtask

    task automatic drive_rect(input int x, input int y, input int w, input int ht, input int n);
        repeat (n) begin
            drive_pos(x + int'($urandom % w), y + int'($urandom % ht));
        end
    endtask

    task automatic drive_sprite(input sprite_id_t id, input int n);
        int w;
        int ht;

        w  = SPR_RIGHT[id] - SPR_LEFT[id];
        ht = SPR_BOTTOM[id] - SPR_TOP[id];
        if (id == SPR_TENS || id == SPR_ONES) begin
            w  = GLYPH_W;
            ht = GLYPH_BOTTOM - GLYPH_TOP;
        end
        drive_rect(SPR_X[id], SPR_Y[id], w, ht, n);
    endtask

    task automatic set_mode(input status_t st, input logic [7:0] num);
        @(negedge clk_100mhz);
        status = st;
        number = num;
        mode_cycle = cycle;
        // enables lag number by two registers
        repeat (3) @(negedge clk_100mhz);
    endtask

    // bar width is k after k*16 cycles so positions keep two pixels off its edge
    task automatic check_bar(input int k);
        while (cycle < mode_cycle + k * 16) begin
            @(negedge clk_100mhz);
        end
        cur_pw = k;
        repeat (6) begin
            drive_pos(int'($urandom % (k - 1)), PROGRESS_Y + int'($urandom % PROGRESS_H));
        end
        repeat (6) begin
            drive_pos(k + 2 + int'($urandom % (SCREEN_W - 2 - k)),
                      PROGRESS_Y + int'($urandom % PROGRESS_H));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_adr(input atlas_adr_t got, input atlas_adr_t exp);
        if (got !== exp) begin
            $display("FAILED sprite_adr got 0x%h expected 0x%h in cycle %0d", got, exp, cycle);
            adr_errors++;
        end
    endtask

    task automatic check_color(input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("FAILED {r_out,g_out,b_out} got 0x%h expected 0x%h in cycle %0d",
                     got, exp, cycle);
            color_errors++;
        end
    endtask

    always @(negedge clk_100mhz) begin
        if (adr_due[3'(cycle)] == cycle) begin
            check_adr(sprite_adr, adr_exp[3'(cycle)]);
        end
        if (rgb_due[3'(cycle)] == cycle) begin
            check_color({r_out, g_out, b_out}, rgb_exp[3'(cycle)]);
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk_100mhz);
        end
        $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(26));
        rst    = 1'b1;
        hcount = '0;
        vcount = '0;
        status = ST_PAUSED;
        number = '0;
        repeat (3) @(negedge clk_100mhz);
        // outputs held at their reset value
        check_adr(sprite_adr, '0);
        check_color({r_out, g_out, b_out}, '0);
        rst = 1'b0;

        // running with three digits
        set_mode(ST_RUNNING, 8'd150);
        drive_rect(TOP_BAR_X, TOP_BAR_Y, TOP_BAR_W, TOP_BAR_H, 10);
        drive_rect(BOTTOM_BAR_X, BOTTOM_BAR_Y, BOTTOM_BAR_W, BOTTOM_BAR_H, 10);
        drive_sprite(SPR_COLLECTING, 10);
        drive_sprite(SPR_BPM, 10);
        drive_sprite(SPR_HUNDREDS, 10);
        drive_sprite(SPR_LOGO, 6);
        // hundreds slot falls back to the red bar
        set_mode(ST_RUNNING, 8'd42);
        drive_sprite(SPR_HUNDREDS, 10);

        repeat (6) begin
            set_mode(ST_RUNNING, 8'($urandom));
            drive_sprite(SPR_TENS, 8);
            drive_sprite(SPR_ONES, 8);
        end

        set_mode(ST_PAUSED, 8'd73);
        drive_rect(TOP_BAR_X, TOP_BAR_Y, TOP_BAR_W, TOP_BAR_H, 8);
        drive_rect(BOTTOM_BAR_X, BOTTOM_BAR_Y, BOTTOM_BAR_W, BOTTOM_BAR_H, 8);
        drive_sprite(SPR_PAUSED_MSG, 10);
        drive_sprite(SPR_TENS, 5);

        // no digits in error so the slots read as grey bar
        set_mode(ST_ERROR, 8'd73);
        drive_rect(TOP_BAR_X, TOP_BAR_Y, TOP_BAR_W, TOP_BAR_H, 6);
        drive_rect(BOTTOM_BAR_X, BOTTOM_BAR_Y, BOTTOM_BAR_W, BOTTOM_BAR_H, 6);
        drive_rect(ERROR_BOX_X, ERROR_BOX_Y, ERROR_BOX_W, ERROR_BOX_H, 10);
        drive_sprite(SPR_ERROR_MSG, 10);
        drive_sprite(SPR_TENS, 6);

        set_mode(ST_BOOT, 8'd73);
        for (int j = 0; j < 3; j++) begin
            check_bar(BAR_STEPS[j]);
        end
        // a trip through paused empties the bar that had reached N_STEPS
        cur_pw = 0;
        set_mode(ST_PAUSED, 8'd73);
        set_mode(ST_BOOT, 8'd73);
        drive_rect(0, PROGRESS_Y, N_STEPS, PROGRESS_H, 8);

        repeat (PIPE_DEPTH + 2) @(negedge clk_100mhz);
        $display("errors: sprite_adr %0d, rgb %0d", adr_errors, color_errors);
        if (adr_errors + color_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
